// ==== files.f ====
+incdir+hdl
hdl/mm_pkg.sv
hdl/mm_ifs.sv
hdl/mm_cfg_regs.sv
hdl/mm_dma_engine.sv
hdl/mm_row_buffer.sv
hdl/mm_mac_array.sv
hdl/mm_top.sv
tb/mm_assertions.sv
tb/tb_mm_top.sv

// ==== hdl/mm_cfg_regs.sv ====
// software register block of the matrix-multiply accelerator
// base addresses, start control and busy/done status
`timescale 1ns/1ps
`include "mm_params.svh"

module mm_cfg_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  reg_we_i,
    input  logic [`MM_REG_AW-1:0] reg_addr_i,
    input  logic [31:0]           reg_wdata_i,
    output logic [31:0]           reg_rdata_o,
    cfg_if.regs                   cfg
);

    logic [`MM_AXI_AW-1:0] a_addr_q;
    logic [`MM_AXI_AW-1:0] b_addr_q;
    logic [`MM_AXI_AW-1:0] c_addr_q;
    logic                  start_q;
    logic                  busy_q;
    logic                  done_sticky_q;
    logic                  go;

    // start request, dropped while a run is active or a start is pending
    assign go = reg_we_i && (reg_addr_i == `MM_REG_CTRL) && reg_wdata_i[0]
                && !busy_q && !start_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_addr_q      <= '0;
            b_addr_q      <= '0;
            c_addr_q      <= '0;
            start_q       <= 1'b0;
            busy_q        <= 1'b0;
            done_sticky_q <= 1'b0;
        end else begin
            // address writes
            if (reg_we_i && (reg_addr_i == `MM_REG_A_ADDR)) begin
                a_addr_q <= reg_wdata_i;
            end
            if (reg_we_i && (reg_addr_i == `MM_REG_B_ADDR)) begin
                b_addr_q <= reg_wdata_i;
            end
            if (reg_we_i && (reg_addr_i == `MM_REG_C_ADDR)) begin
                c_addr_q <= reg_wdata_i;
            end

            // one-cycle start pulse
            start_q <= go;

            // busy from start until done
            if (start_q) begin
                busy_q <= 1'b1;
            end else if (cfg.done) begin
                busy_q <= 1'b0;
            end

            // sticky done, cleared by the next start
            if (cfg.done) begin
                done_sticky_q <= 1'b1;
            end else if (start_q) begin
                done_sticky_q <= 1'b0;
            end
        end
    end

    // read mux, unmapped and CTRL read zero
    always_comb begin
        case (reg_addr_i)
            `MM_REG_A_ADDR: reg_rdata_o = a_addr_q;
            `MM_REG_B_ADDR: reg_rdata_o = b_addr_q;
            `MM_REG_C_ADDR: reg_rdata_o = c_addr_q;
            `MM_REG_STATUS: reg_rdata_o = {30'b0, done_sticky_q, busy_q};
            default:        reg_rdata_o = 32'b0;
        endcase
    end

    assign cfg.a_addr = a_addr_q;
    assign cfg.b_addr = b_addr_q;
    assign cfg.c_addr = c_addr_q;
    assign cfg.start  = start_q;

endmodule

// ==== hdl/mm_dma_engine.sv ====
// DMA engine of the matrix-multiply accelerator
// reads A then B as 16-beat AXI bursts into the buffers, starts the MAC array,
// then writes the 4x4 product back as one 16-beat burst
`timescale 1ns/1ps
`include "mm_params.svh"

module mm_dma_engine
    import mm_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    cfg_if.dma                    cfg,
    buf_wr_if.src                 buf_a,
    buf_wr_if.src                 buf_b,
    // MAC array control
    output logic                  mac_start_o,
    input  logic                  mac_done_i,
    input  acc_mat_t              acc_i,
    // AR channel
    output logic                  arvalid_o,
    input  logic                  arready_i,
    output logic [`MM_AXI_AW-1:0] araddr_o,
    output logic [7:0]            arlen_o,
    // R channel
    input  logic                  rvalid_i,
    output logic                  rready_o,
    input  logic [`MM_AXI_DW-1:0] rdata_i,
    input  logic                  rlast_i,
    // AW channel
    output logic                  awvalid_o,
    input  logic                  awready_i,
    output logic [`MM_AXI_AW-1:0] awaddr_o,
    output logic [7:0]            awlen_o,
    // W channel
    output logic                  wvalid_o,
    input  logic                  wready_i,
    output logic [`MM_AXI_DW-1:0] wdata_o,
    output logic                  wlast_o,
    // B channel
    input  logic                  bvalid_i,
    output logic                  bready_o
);

    dma_state_t state_q;
    // read beats 0..31, bit 4 selects B; write beats 0..15
    logic [4:0] beat_q;
    logic       done_q;
    logic       mac_start_q;

    logic       ar_hs;
    logic       r_hs;
    logic       aw_hs;
    logic       w_hs;
    logic       b_hs;
    logic [3:0] n;
    elem_t      r_elem;

    assign ar_hs = arvalid_o && arready_i;
    assign r_hs  = rvalid_i && rready_o;
    assign aw_hs = awvalid_o && awready_i;
    assign w_hs  = wvalid_o && wready_i;
    assign b_hs  = bvalid_i && bready_o;

    // beat index within the current burst
    assign n = beat_q[3:0];

    // low half of the sign-extended beat
    assign r_elem = rdata_i[`MM_ELEM_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= IDLE;
            beat_q      <= '0;
            done_q      <= 1'b0;
            mac_start_q <= 1'b0;
        end else begin
            done_q      <= 1'b0;
            mac_start_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (cfg.start) begin
                        beat_q  <= '0;
                        state_q <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (ar_hs) begin
                        state_q <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (r_hs) begin
                        beat_q <= beat_q + 5'd1;
                        if (rlast_i) begin
                            // second burst done, hand over to the array
                            if (beat_q[4]) begin
                                mac_start_q <= 1'b1;
                                state_q     <= COMPUTE;
                            end else begin
                                state_q <= RD_ADDR;
                            end
                        end
                    end
                end
                COMPUTE: begin
                    if (mac_done_i) begin
                        state_q <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    if (aw_hs) begin
                        beat_q  <= '0;
                        state_q <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_hs) begin
                        beat_q <= beat_q + 5'd1;
                        if (wlast_o) begin
                            state_q <= WR_RESP;
                        end
                    end
                end
                WR_RESP: begin
                    if (b_hs) begin
                        done_q  <= 1'b1;
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // channel strobes straight from the state, so they hold until the handshake
    assign arvalid_o = (state_q == RD_ADDR);
    assign araddr_o  = beat_q[4] ? cfg.b_addr : cfg.a_addr;
    assign arlen_o   = 8'(`MM_BURST_LEN - 1);
    assign rready_o  = (state_q == RD_DATA);

    assign awvalid_o = (state_q == WR_ADDR);
    assign awaddr_o  = cfg.c_addr;
    assign awlen_o   = 8'(`MM_BURST_LEN - 1);

    // beat n is acc row n/4, column n%4
    assign wvalid_o  = (state_q == WR_DATA);
    assign wdata_o   = acc_i[n[3:2]][n[1:0]];
    assign wlast_o   = (n == 4'(`MM_BURST_LEN - 1));

    assign bready_o  = (state_q == WR_RESP);

    // A goes column-wise: word n%4, lane n/4
    assign buf_a.wr_en   = r_hs && !beat_q[4];
    assign buf_a.wr_addr = n[1:0];
    assign buf_a.lane_en = `MM_N'(1) << n[3:2];
    assign buf_a.wr_data = {`MM_N{r_elem}};

    // B goes row-wise: word n/4, lane n%4
    assign buf_b.wr_en   = r_hs && beat_q[4];
    assign buf_b.wr_addr = n[3:2];
    assign buf_b.lane_en = `MM_N'(1) << n[1:0];
    assign buf_b.wr_data = {`MM_N{r_elem}};

    assign mac_start_o = mac_start_q;
    assign cfg.done    = done_q;

endmodule

// ==== hdl/mm_ifs.sv ====
// internal interfaces of the matrix-multiply accelerator
// cfg_if carries addresses and start/done between the registers and the DMA engine,
// buf_wr_if carries one buffer write port from the DMA engine
`timescale 1ns/1ps
`include "mm_params.svh"

interface cfg_if;
    // base addresses, held by the register block
    logic [`MM_AXI_AW-1:0] a_addr;
    logic [`MM_AXI_AW-1:0] b_addr;
    logic [`MM_AXI_AW-1:0] c_addr;
    // one-cycle pulses
    logic                  start;
    logic                  done;

    modport regs (
        output a_addr, b_addr, c_addr, start,
        input  done
    );

    modport dma (
        input  a_addr, b_addr, c_addr, start,
        output done
    );
endinterface

interface buf_wr_if;
    logic                            wr_en;
    logic [$clog2(`MM_N)-1:0]        wr_addr;
    // one bit per element lane
    logic [`MM_N-1:0]                lane_en;
    // same layout as one elem_row_t
    logic [`MM_N*`MM_ELEM_W-1:0]     wr_data;

    modport src (
        output wr_en, wr_addr, lane_en, wr_data
    );

    modport sink (
        input  wr_en, wr_addr, lane_en, wr_data
    );
endinterface

// ==== hdl/mm_mac_array.sv ====
// output-stationary 4x4 multiply-accumulate array
// steps k over the shared dimension, cell (i,j) adds a[i][k] * b[k][j]
`timescale 1ns/1ps
`include "mm_params.svh"

module mm_mac_array
    import mm_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start_i,
    output logic [$clog2(`MM_N)-1:0] rd_addr_o,
    input  elem_row_t                a_col_i,
    input  elem_row_t                b_row_i,
    output acc_mat_t                 acc_o,
    output logic                     done_o
);

    localparam int KW = $clog2(`MM_N);

    logic [KW-1:0] k_q;
    // address phase, then data phase one cycle later
    logic          issue_q;
    logic          acc_en_q;
    logic          acc_last_q;
    logic          done_q;
    acc_mat_t      acc_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            k_q        <= '0;
            issue_q    <= 1'b0;
            acc_en_q   <= 1'b0;
            acc_last_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            if (start_i) begin
                k_q     <= '0;
                issue_q <= 1'b1;
            end else if (issue_q) begin
                k_q <= k_q + 1'b1;
                // last address issued
                if (k_q == KW'(`MM_N - 1)) begin
                    issue_q <= 1'b0;
                end
            end
            // buffer data lands one cycle after the address
            acc_en_q   <= issue_q;
            acc_last_q <= issue_q && (k_q == KW'(`MM_N - 1));
            done_q     <= acc_last_q;
        end
    end

    // accumulators, cleared by start and held afterwards
    always_ff @(posedge clk) begin
        if (start_i) begin
            acc_q <= '0;
        end else if (acc_en_q) begin
            for (int i = 0; i < `MM_N; i++) begin
                for (int j = 0; j < `MM_N; j++) begin
                    // signed 16x16 fits 32 bits, sum wraps
                    acc_q[i][j] <= acc_q[i][j] + a_col_i[i] * b_row_i[j];
                end
            end
        end
    end

    assign rd_addr_o = k_q;
    assign acc_o     = acc_q;
    assign done_o    = done_q;

endmodule

// ==== hdl/mm_params.svh ====
// matrix-multiply accelerator parameters
// sizes, widths and register offsets shared by the RTL and the testbench
`ifndef MM_PARAMS_SVH
`define MM_PARAMS_SVH

// matrix geometry
`define MM_N            4
`define MM_ELEM_W       16
`define MM_ACC_W        32

// axi master
`define MM_AXI_AW       32
`define MM_AXI_DW       32
`define MM_BURST_LEN    16

// register port, word offsets
`define MM_REG_AW       3
`define MM_REG_A_ADDR   0
`define MM_REG_B_ADDR   1
`define MM_REG_C_ADDR   2
`define MM_REG_CTRL     3
`define MM_REG_STATUS   4

`endif

// ==== hdl/mm_pkg.sv ====
// matrix-multiply accelerator types
// element, buffer row, accumulator matrix and DMA FSM state
`include "mm_params.svh"

package mm_pkg;

    // one matrix element, sign-extended on the bus
    typedef logic signed [`MM_ELEM_W-1:0] elem_t;

    // one buffer word
    // column of A or row of B, lane i is element i
    typedef elem_t [`MM_N-1:0] elem_row_t;

    // accumulator, wraps at 32 bits
    typedef logic signed [`MM_ACC_W-1:0] acc_t;

    // full product, indexed [row][col]
    typedef acc_t [`MM_N-1:0][`MM_N-1:0] acc_mat_t;

    // DMA engine FSM
    typedef enum logic [2:0] {
        IDLE,
        RD_ADDR,
        RD_DATA,
        COMPUTE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } dma_state_t;

endpackage

// ==== hdl/mm_row_buffer.sv ====
// element-row buffer
// four words, lane-wise write enable, registered read
`timescale 1ns/1ps
`include "mm_params.svh"

module mm_row_buffer
    import mm_pkg::*;
(
    input  logic                     clk,
    buf_wr_if.sink                   wr,
    input  logic [$clog2(`MM_N)-1:0] rd_addr_i,
    output elem_row_t                rd_data_o
);

    elem_row_t mem [`MM_N];
    elem_row_t wr_row;

    // view the write bus as element lanes
    assign wr_row = wr.wr_data;

    always_ff @(posedge clk) begin
        // only enabled lanes change
        if (wr.wr_en) begin
            for (int l = 0; l < `MM_N; l++) begin
                if (wr.lane_en[l]) begin
                    mem[wr.wr_addr][l] <= wr_row[l];
                end
            end
        end
        // data one cycle after the address
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// ==== hdl/mm_top.sv ====
// matrix-multiply accelerator top level
// register block, DMA engine with AXI master, A/B buffers and MAC array
`timescale 1ns/1ps
`include "mm_params.svh"

module mm_top
    import mm_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // register port
    input  logic                  reg_we_i,
    input  logic [`MM_REG_AW-1:0] reg_addr_i,
    input  logic [31:0]           reg_wdata_i,
    output logic [31:0]           reg_rdata_o,
    // AXI master
    output logic                  arvalid_o,
    input  logic                  arready_i,
    output logic [`MM_AXI_AW-1:0] araddr_o,
    output logic [7:0]            arlen_o,
    input  logic                  rvalid_i,
    output logic                  rready_o,
    input  logic [`MM_AXI_DW-1:0] rdata_i,
    input  logic                  rlast_i,
    output logic                  awvalid_o,
    input  logic                  awready_i,
    output logic [`MM_AXI_AW-1:0] awaddr_o,
    output logic [7:0]            awlen_o,
    output logic                  wvalid_o,
    input  logic                  wready_i,
    output logic [`MM_AXI_DW-1:0] wdata_o,
    output logic                  wlast_o,
    input  logic                  bvalid_i,
    output logic                  bready_o
);

    cfg_if    cfg_bus ();
    buf_wr_if wr_a ();
    buf_wr_if wr_b ();

    logic                     mac_start;
    logic                     mac_done;
    acc_mat_t                 acc;
    // both buffers read at the same step address
    logic [$clog2(`MM_N)-1:0] rd_addr;
    elem_row_t                a_col;
    elem_row_t                b_row;

    mm_cfg_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .cfg         (cfg_bus.regs)
    );

    mm_dma_engine u_dma (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg_bus.dma),
        .buf_a       (wr_a.src),
        .buf_b       (wr_b.src),
        .mac_start_o (mac_start),
        .mac_done_i  (mac_done),
        .acc_i       (acc),
        .arvalid_o   (arvalid_o),
        .arready_i   (arready_i),
        .araddr_o    (araddr_o),
        .arlen_o     (arlen_o),
        .rvalid_i    (rvalid_i),
        .rready_o    (rready_o),
        .rdata_i     (rdata_i),
        .rlast_i     (rlast_i),
        .awvalid_o   (awvalid_o),
        .awready_i   (awready_i),
        .awaddr_o    (awaddr_o),
        .awlen_o     (awlen_o),
        .wvalid_o    (wvalid_o),
        .wready_i    (wready_i),
        .wdata_o     (wdata_o),
        .wlast_o     (wlast_o),
        .bvalid_i    (bvalid_i),
        .bready_o    (bready_o)
    );

    // word k holds column k of A
    mm_row_buffer u_buf_a (
        .clk       (clk),
        .wr        (wr_a.sink),
        .rd_addr_i (rd_addr),
        .rd_data_o (a_col)
    );

    // word k holds row k of B
    mm_row_buffer u_buf_b (
        .clk       (clk),
        .wr        (wr_b.sink),
        .rd_addr_i (rd_addr),
        .rd_data_o (b_row)
    );

    mm_mac_array u_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (mac_start),
        .rd_addr_o (rd_addr),
        .a_col_i   (a_col),
        .b_row_i   (b_row),
        .acc_o     (acc),
        .done_o    (mac_done)
    );

endmodule

// ==== tb/mm_assertions.sv ====
// protocol checks for the matrix-multiply accelerator
// AXI request stability, one-cycle pulses and buffer writes inside read bursts
`timescale 1ns/1ps
`include "mm_params.svh"

module mm_assertions (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  arvalid_i,
    input logic                  arready_i,
    input logic [`MM_AXI_AW-1:0] araddr_i,
    input logic [7:0]            arlen_i,
    input logic                  rvalid_i,
    input logic                  rready_i,
    input logic                  rlast_i,
    input logic                  awvalid_i,
    input logic                  awready_i,
    input logic [`MM_AXI_AW-1:0] awaddr_i,
    input logic [7:0]            awlen_i,
    input logic                  wvalid_i,
    input logic                  wready_i,
    input logic [`MM_AXI_DW-1:0] wdata_i,
    input logic                  wlast_i,
    input logic                  start_i,
    input logic                  done_i,
    input logic                  mac_start_i,
    input logic                  mac_done_i,
    input logic                  wr_a_en_i,
    input logic                  wr_b_en_i
);

    logic rd_burst_q;

    // read burst seen on the bus, from the AR transfer to the R transfer with rlast
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_burst_q <= 1'b0;
        end else if (arvalid_i && arready_i) begin
            rd_burst_q <= 1'b1;
        end else if (rvalid_i && rready_i && rlast_i) begin
            rd_burst_q <= 1'b0;
        end
    end

    // valid and payload held until ready
    assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i) && $stable(arlen_i))
        else $error("AR request dropped or changed before arready");
    assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i) && $stable(awlen_i))
        else $error("AW request dropped or changed before awready");
    assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wlast_i))
        else $error("W beat dropped or changed before wready");

    // single-cycle pulses
    assert property (@(posedge clk) disable iff (!rst_n) start_i |=> !start_i)
        else $error("start longer than one cycle");
    assert property (@(posedge clk) disable iff (!rst_n) done_i |=> !done_i)
        else $error("done longer than one cycle");
    assert property (@(posedge clk) disable iff (!rst_n) mac_start_i |=> !mac_start_i)
        else $error("mac_start longer than one cycle");
    assert property (@(posedge clk) disable iff (!rst_n) mac_done_i |=> !mac_done_i)
        else $error("mac_done longer than one cycle");

    // buffers are filled only from R beats of an open read burst
    assert property (@(posedge clk) disable iff (!rst_n)
        (wr_a_en_i || wr_b_en_i) |-> rd_burst_q && rvalid_i && rready_i)
        else $error("buffer write outside RD_DATA");

endmodule

bind mm_top mm_assertions u_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .arvalid_i   (arvalid_o),
    .arready_i   (arready_i),
    .araddr_i    (araddr_o),
    .arlen_i     (arlen_o),
    .rvalid_i    (rvalid_i),
    .rready_i    (rready_o),
    .rlast_i     (rlast_i),
    .awvalid_i   (awvalid_o),
    .awready_i   (awready_i),
    .awaddr_i    (awaddr_o),
    .awlen_i     (awlen_o),
    .wvalid_i    (wvalid_o),
    .wready_i    (wready_i),
    .wdata_i     (wdata_o),
    .wlast_i     (wlast_o),
    .start_i     (cfg_bus.start),
    .done_i      (cfg_bus.done),
    .mac_start_i (mac_start),
    .mac_done_i  (mac_done),
    .wr_a_en_i   (wr_a.wr_en),
    .wr_b_en_i   (wr_b.wr_en)
);

// ==== tb/tb_mm_top.sv ====
// testbench for the matrix-multiply accelerator
// register driver, random-latency AXI memory model, reference multiply and checks
`timescale 1ns/1ps
`include "mm_params.svh"

module tb_mm_top;

    localparam int CLK_PERIOD      = 100;
    localparam int N_RUNS          = 6;
    localparam int WATCHDOG_CYCLES = N_RUNS * 400;

    logic        clk;
    logic        rst_n;
    logic        reg_we;
    logic [2:0]  reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;
    logic        arvalid, arready, rvalid, rready, rlast;
    logic        awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic [31:0] araddr, rdata, awaddr, wdata;
    logic [7:0]  arlen, awlen;

    integer seed = 41;
    int     errors = 0;
    int     checks = 0;

    // word-addressed memory behind the AXI master
    logic [31:0] mem [int unsigned];
    // requests seen by the memory model in the current run
    logic [31:0] ar_addr_q [$];
    logic [7:0]  ar_len_q [$];
    logic [31:0] aw_addr_q [$];
    logic [7:0]  aw_len_q [$];
    logic        w_last_q [$];

    // operands and model result
    logic signed [15:0] a_m [4][4];
    logic signed [15:0] b_m [4][4];
    logic [31:0]        c_exp [4][4];

    mm_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_we_i    (reg_we),
        .reg_addr_i  (reg_addr),
        .reg_wdata_i (reg_wdata),
        .reg_rdata_o (reg_rdata),
        .arvalid_o   (arvalid),
        .arready_i   (arready),
        .araddr_o    (araddr),
        .arlen_o     (arlen),
        .rvalid_i    (rvalid),
        .rready_o    (rready),
        .rdata_i     (rdata),
        .rlast_i     (rlast),
        .awvalid_o   (awvalid),
        .awready_i   (awready),
        .awaddr_o    (awaddr),
        .awlen_o     (awlen),
        .wvalid_o    (wvalid),
        .wready_i    (wready),
        .wdata_o     (wdata),
        .wlast_o     (wlast),
        .bvalid_i    (bvalid),
        .bready_o    (bready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    // one-cycle write strobe driven from a falling edge
    task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
        @(negedge clk);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_we    = 1'b0;
    endtask

    // combinational read data sampled well before the next rising edge
    task automatic reg_read(input logic [2:0] addr, output logic [31:0] data);
        @(negedge clk);
        reg_addr = addr;
        #10;
        data = reg_rdata;
    endtask

    // C = A x B with sums wrapping at 32 bits
    function automatic void compute_expected();
        int sum;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                sum = 0;
                for (int k = 0; k < 4; k++) begin
                    sum += int'(a_m[i][k]) * int'(b_m[k][j]);
                end
                c_exp[i][j] = sum;
            end
        end
    endfunction

    // one full multiply with an optional second CTRL write while busy
    task automatic run_matmul(input bit try_restart);
        logic [31:0] a_addr, b_addr, c_addr, st, got;
        int unsigned n;
        // separate 256-byte aligned regions
        a_addr = 32'h1000_0000 | (({$random(seed)} % 256) << 8);
        b_addr = 32'h2000_0000 | (({$random(seed)} % 256) << 8);
        c_addr = 32'h3000_0000 | (({$random(seed)} % 256) << 8);
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                n = r * 4 + c;
                a_m[r][c] = 16'($random(seed));
                b_m[r][c] = 16'($random(seed));
                mem[(a_addr >> 2) + n] = {{16{a_m[r][c][15]}}, a_m[r][c]};
                mem[(b_addr >> 2) + n] = {{16{b_m[r][c][15]}}, b_m[r][c]};
                // stale results must not pass
                mem.delete((c_addr >> 2) + n);
            end
        end
        compute_expected();
        ar_addr_q.delete();
        ar_len_q.delete();
        aw_addr_q.delete();
        aw_len_q.delete();
        w_last_q.delete();

        reg_write(`MM_REG_A_ADDR, a_addr);
        reg_write(`MM_REG_B_ADDR, b_addr);
        reg_write(`MM_REG_C_ADDR, c_addr);
        reg_write(`MM_REG_CTRL, 32'd1);
        // busy set and done_sticky cleared by start
        reg_read(`MM_REG_STATUS, st);
        check("status during run", 32'd1, st);
        if (try_restart) begin
            // CTRL write while busy in the cycle of the B transfer
            // an ungated start would land in the done cycle with the FSM back in IDLE
            @(posedge bvalid);
            reg_we    = 1'b1;
            reg_addr  = `MM_REG_CTRL;
            reg_wdata = 32'd1;
            @(negedge clk);
            reg_we    = 1'b0;
        end
        do begin
            reg_read(`MM_REG_STATUS, st);
        end while (!st[1]);
        check("status after done", 32'd2, st);

        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                n = (c_addr >> 2) + r * 4 + c;
                got = mem.exists(n) ? mem[n] : 32'hxxxx_xxxx;
                check($sformatf("c[%0d][%0d]", r, c), c_exp[r][c], got);
            end
        end

        // an ignored restart leaves exactly two AR requests
        check("ar count", 32'd2, ar_addr_q.size());
        if (ar_addr_q.size() >= 2) begin
            check("araddr first", a_addr, ar_addr_q[0]);
            check("araddr second", b_addr, ar_addr_q[1]);
            check("arlen first", 32'd15, ar_len_q[0]);
            check("arlen second", 32'd15, ar_len_q[1]);
        end
        check("aw count", 32'd1, aw_addr_q.size());
        if (aw_addr_q.size() >= 1) begin
            check("awaddr", c_addr, aw_addr_q[0]);
            check("awlen", 32'd15, aw_len_q[0]);
        end
        check("w beat count", 32'd16, w_last_q.size());
        foreach (w_last_q[i]) begin
            check($sformatf("wlast beat %0d", i), 32'(i == 15), 32'(w_last_q[i]));
        end
    endtask

    // AR and R side of the memory model
    initial begin : read_slave
        int unsigned base;
        int          len;
        wait (rst_n);
        forever begin
            @(negedge clk);
            if (arvalid) begin
                repeat ({$random(seed)} % 4) @(negedge clk);
                arready = 1'b1;
                ar_addr_q.push_back(araddr);
                ar_len_q.push_back(arlen);
                base = araddr >> 2;
                len  = arlen;
                @(negedge clk);
                arready = 1'b0;
                for (int b = 0; b <= len; b++) begin
                    // random gap before each beat
                    repeat ({$random(seed)} % 3) @(negedge clk);
                    rvalid = 1'b1;
                    rdata  = mem.exists(base + b) ? mem[base + b] : 32'hxxxx_xxxx;
                    rlast  = (b == len);
                    // rready only moves on rising edges
                    while (!rready) @(negedge clk);
                    @(negedge clk);
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                end
            end
        end
    end

    // AW, W and B side of the memory model
    initial begin : write_slave
        int unsigned base;
        int          beat;
        logic        last;
        wait (rst_n);
        forever begin
            @(negedge clk);
            if (awvalid) begin
                repeat ({$random(seed)} % 4) @(negedge clk);
                awready = 1'b1;
                aw_addr_q.push_back(awaddr);
                aw_len_q.push_back(awlen);
                base = awaddr >> 2;
                @(negedge clk);
                awready = 1'b0;
                beat = 0;
                last = 1'b0;
                while (!last) begin
                    while (!wvalid) @(negedge clk);
                    repeat ({$random(seed)} % 4) @(negedge clk);
                    wready = 1'b1;
                    // beat is stable until the rising edge that takes it
                    mem[base + beat] = wdata;
                    last = wlast;
                    w_last_q.push_back(wlast);
                    beat++;
                    @(negedge clk);
                    wready = 1'b0;
                end
                repeat (1 + {$random(seed)} % 3) @(negedge clk);
                bvalid = 1'b1;
                while (!bready) @(negedge clk);
                @(negedge clk);
                bvalid = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: runs did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        logic [31:0] st;
        logic [31:0] val [3];
        reg_we    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rdata     = '0;
        rlast     = 1'b0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        rst_n     = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // register readback and idle status
        reg_read(`MM_REG_STATUS, st);
        check("status after reset", 32'd0, st);
        for (int i = 0; i < 3; i++) begin
            val[i] = $random(seed);
            reg_write(3'(`MM_REG_A_ADDR + i), val[i]);
        end
        for (int i = 0; i < 3; i++) begin
            reg_read(3'(`MM_REG_A_ADDR + i), st);
            check($sformatf("addr reg %0d", i), val[i], st);
        end

        // odd runs also try a restart while busy
        for (int run = 0; run < N_RUNS; run++) begin
            run_matmul(run % 2 == 1);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
